// File: rcn_settings.svh
`ifndef RCN_SETTINGS_SVH
`define RCN_SETTINGS_SVH

// Ring size and buffering for the rcn ring bus.

// Number of master stations between the slave output and the slave input.
// Station ids are 4 bits wide, so at most 16 stations fit on one ring.
`define RCN_NUM_MASTERS 3

// Request buffer entries in front of each station.
// Must be a power of two so the pointers wrap on their own.
`define RCN_BUF_DEPTH 4

// Slave memory depth in 32-bit words.
`define RCN_MEM_WORDS 256

// Word-address bits used to index the slave memory.
// Higher address bits are ignored, so the memory aliases.
`define RCN_MEM_AW 8

`endif

// File: rcn_pkg.sv
`default_nettype none

package rcn_pkg;

  typedef logic [3:0]  rcn_id_t;     // station id carried on the ring.
  typedef logic [1:0]  rcn_seq_t;    // request tag chosen by the user.
  typedef logic [3:0]  rcn_mask_t;   // one enable per byte lane.
  typedef logic [19:0] rcn_waddr_t;  // word address on the ring.
  typedef logic [21:0] rcn_baddr_t;  // byte address at the user ports.
  typedef logic [31:0] rcn_data_t;

  // One ring slot.
  // A set pending bit marks a request, a clear one marks a response.
  // The we field holds the byte mask of a write and is zero for a read.
  typedef struct packed {
    logic       valid;
    logic       pending;
    rcn_id_t    id;
    rcn_seq_t   seq;
    rcn_mask_t  we;
    rcn_waddr_t addr;
    rcn_data_t  data;
  } rcn_bus_t;

  // Request as it is held in the station buffer.
  typedef struct packed {
    rcn_seq_t   seq;
    logic       wr;
    rcn_mask_t  mask;
    rcn_waddr_t addr;
    rcn_data_t  wdata;
  } rcn_req_t;

  // Response handed back to the user of a station.
  typedef struct packed {
    rcn_seq_t   seq;
    rcn_mask_t  mask;
    rcn_baddr_t addr;    // byte address with the two low bits zero.
    rcn_data_t  data;
  } rcn_rsp_t;

endpackage

`default_nettype wire

// File: rcn_master.sv
`timescale 1ns/1ps
`default_nettype none

module rcn_master #(
  parameter int MASTER_ID = 0
) (
  input  wire                clk,
  input  wire                rst,

  input  wire rcn_pkg::rcn_bus_t  rcn_in,
  output rcn_pkg::rcn_bus_t       rcn_out,

  input  wire                cs,
  input  wire rcn_pkg::rcn_req_t  req,
  output logic               busy,

  output logic               rdone,
  output logic               wdone,
  output rcn_pkg::rcn_rsp_t       rsp
);

  localparam rcn_pkg::rcn_id_t MY_ID = rcn_pkg::rcn_id_t'(MASTER_ID);

  logic              own_rsp;
  logic              slot_free;
  logic              inject;
  rcn_pkg::rcn_bus_t req_word;
  rcn_pkg::rcn_bus_t nxt_word;

  // a response is ours only when pending is clear and the id matches.
  assign own_rsp = rcn_in.valid && !rcn_in.pending && (rcn_in.id == MY_ID);

  // Removing our own response frees the slot in the same cycle,
  // so a new request can take its place right away.
  assign slot_free = !rcn_in.valid || own_rsp;
  assign busy      = !slot_free;  // nothing can be placed on the ring now.
  assign inject    = cs && slot_free;

  // Build the ring word for the local request.
  always_comb begin
    req_word         = '0;
    req_word.valid   = 1'b1;
    req_word.pending = 1'b1;
    req_word.id      = MY_ID;
    req_word.seq     = req.seq;
    req_word.addr    = req.addr;
    if (req.wr) begin
      req_word.we   = req.mask;   // reads leave the mask at zero.
      req_word.data = req.wdata;
    end
  end

  // choose what leaves this station on the next cycle.
  always_comb begin
    if (inject) begin
      nxt_word = req_word;
    end else if (own_rsp) begin
      nxt_word = '0;              // the consumed response leaves an empty slot.
    end else begin
      nxt_word = rcn_in;          // foreign traffic goes on unchanged.
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      rcn_out <= '0;
    end else begin
      rcn_out <= nxt_word;        // one register stage per hop.
    end
  end

  // A write response still carries its byte mask, a read response does not.
  assign rdone = own_rsp && (rcn_in.we == '0);
  assign wdone = own_rsp && (rcn_in.we != '0);

  always_comb begin
    rsp.seq  = rcn_in.seq;
    rsp.mask = rcn_in.we;
    rsp.addr = {rcn_in.addr, 2'b00};  // back to a byte address.
    rsp.data = rcn_in.data;
  end

endmodule

`default_nettype wire

// File: rcn_master_buf.sv
`timescale 1ns/1ps
`default_nettype none
`include "rcn_settings.svh"

module rcn_master_buf #(
  parameter int MASTER_ID = 0
) (
  input  wire                clk,
  input  wire                rst,

  input  wire rcn_pkg::rcn_bus_t  rcn_in,
  output rcn_pkg::rcn_bus_t       rcn_out,

  input  wire                cs,
  input  wire rcn_pkg::rcn_req_t  req,
  output logic               busy,

  output logic               issue,
  output rcn_pkg::rcn_seq_t       iss_seq,

  output logic               rdone,
  output logic               wdone,
  output rcn_pkg::rcn_rsp_t       rsp
);

  localparam int PTR_W = $clog2(`RCN_BUF_DEPTH);

  rcn_pkg::rcn_req_t buf_mem [`RCN_BUF_DEPTH];
  logic [PTR_W-1:0]  wr_ptr;
  logic [PTR_W-1:0]  rd_ptr;
  logic [PTR_W:0]    count;
  logic              push;
  logic              pop;
  logic              head_vld;
  logic              stn_busy;
  rcn_pkg::rcn_req_t head;

  assign busy     = (count == (PTR_W+1)'(`RCN_BUF_DEPTH));  // high only when full.
  assign push     = cs && !busy;
  assign head_vld = (count != '0);
  assign head     = buf_mem[rd_ptr];
  assign pop      = head_vld && !stn_busy;  // the station takes the head this cycle.

  assign issue   = pop;
  assign iss_seq = head.seq;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;
      if (pop) rd_ptr <= rd_ptr + 1'b1;
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;    // both or neither leave the level unchanged.
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (push) buf_mem[wr_ptr] <= req;
  end

  rcn_master #(
    .MASTER_ID (MASTER_ID)
  ) u_master (
    .clk     (clk),
    .rst     (rst),
    .rcn_in  (rcn_in),
    .rcn_out (rcn_out),
    .cs      (head_vld),
    .req     (head),
    .busy    (stn_busy),
    .rdone   (rdone),
    .wdone   (wdone),
    .rsp     (rsp)
  );

endmodule

`default_nettype wire

// File: rcn_slave_mem.sv
`timescale 1ns/1ps
`default_nettype none
`include "rcn_settings.svh"

module rcn_slave_mem (
  input  wire                clk,
  input  wire                rst,

  input  wire rcn_pkg::rcn_bus_t  rcn_in,
  output rcn_pkg::rcn_bus_t       rcn_out
);

  localparam int AW    = `RCN_MEM_AW;
  localparam int LANES = $bits(rcn_pkg::rcn_mask_t);

  rcn_pkg::rcn_data_t mem [`RCN_MEM_WORDS];

  logic               is_req;
  logic               is_wr;
  logic [AW-1:0]      idx;
  rcn_pkg::rcn_data_t old_word;
  rcn_pkg::rcn_data_t new_word;
  rcn_pkg::rcn_bus_t  rsp_word;

  // Every pending word is served here, whatever its address.
  assign is_req = rcn_in.valid && rcn_in.pending;
  assign is_wr  = is_req && (rcn_in.we != '0);

  // only the low word-address bits select the memory row.
  assign idx      = rcn_in.addr[AW-1:0];
  assign old_word = mem[idx];

  // byte merge of the write data over the stored word.
  always_comb begin
    for (int b = 0; b < LANES; b++) begin
      if (rcn_in.we[b]) begin
        new_word[8*b +: 8] = rcn_in.data[8*b +: 8];
      end else begin
        new_word[8*b +: 8] = old_word[8*b +: 8];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (is_wr) mem[idx] <= new_word;
  end

  // The response keeps id, seq, mask and address of the request.
  // With a zero mask the merged word is simply the stored word,
  // so reads and writes share the same data path.
  always_comb begin
    rsp_word         = rcn_in;
    rsp_word.pending = 1'b0;
    rsp_word.data    = new_word;
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      rcn_out <= '0;
    end else if (is_req) begin
      rcn_out <= rsp_word;
    end else begin
      rcn_out <= rcn_in;    // responses and empty slots just move on.
    end
  end

endmodule

`default_nettype wire

// File: rcn_ring_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "rcn_settings.svh"

module rcn_ring_top (
  input  wire                         clk,
  input  wire                         rst,

  input  wire [`RCN_NUM_MASTERS-1:0]  cs,
  input  wire rcn_pkg::rcn_req_t      req [`RCN_NUM_MASTERS],
  output logic [`RCN_NUM_MASTERS-1:0] busy,

  output logic [`RCN_NUM_MASTERS-1:0] issue,
  output rcn_pkg::rcn_seq_t           iss_seq [`RCN_NUM_MASTERS],

  output logic [`RCN_NUM_MASTERS-1:0] rdone,
  output logic [`RCN_NUM_MASTERS-1:0] wdone,
  output rcn_pkg::rcn_rsp_t           rsp [`RCN_NUM_MASTERS]
);

  // ring[k] feeds station k; ring[N] goes back into the slave.
  rcn_pkg::rcn_bus_t ring [`RCN_NUM_MASTERS+1];

  rcn_slave_mem u_slave (
    .clk     (clk),
    .rst     (rst),
    .rcn_in  (ring[`RCN_NUM_MASTERS]),
    .rcn_out (ring[0])
  );

  for (genvar k = 0; k < `RCN_NUM_MASTERS; k++) begin : g_stn
    rcn_master_buf #(
      .MASTER_ID (k)
    ) u_stn (
      .clk     (clk),
      .rst     (rst),
      .rcn_in  (ring[k]),
      .rcn_out (ring[k+1]),
      .cs      (cs[k]),
      .req     (req[k]),
      .busy    (busy[k]),
      .issue   (issue[k]),
      .iss_seq (iss_seq[k]),
      .rdone   (rdone[k]),
      .wdone   (wdone[k]),
      .rsp     (rsp[k])
    );
  end

endmodule

`default_nettype wire

// File: rcn_ring_asserts.sv
`timescale 1ns/1ps
`default_nettype none
`include "rcn_settings.svh"

module rcn_ring_asserts (
  input wire                              clk,
  input wire                              rst,
  input wire                              cs,
  input wire                              busy,
  input wire                              issue,
  input wire                              rdone,
  input wire                              wdone,
  input wire [$clog2(`RCN_BUF_DEPTH):0]   count
);

  localparam logic [$clog2(`RCN_BUF_DEPTH):0] FULL = `RCN_BUF_DEPTH;

  // a request held against a full buffer must not raise the fill level.
  a_no_push_when_busy: assert property (
    @(posedge clk) disable iff (rst)
    (cs && busy) |=> (count <= $past(count))
  ) else $error("a request entered a full buffer");

  // The station can only take what the buffer holds.
  a_issue_needs_entry: assert property (
    @(posedge clk) disable iff (rst)
    issue |-> (count != '0)
  ) else $error("issue raised with an empty buffer");

  a_done_exclusive: assert property (
    @(posedge clk) disable iff (rst)
    !(rdone && wdone)
  ) else $error("rdone and wdone raised in the same cycle");

  a_count_bound: assert property (
    @(posedge clk) disable iff (rst)
    count <= FULL
  ) else $error("buffer level above its depth");

endmodule

bind rcn_master_buf rcn_ring_asserts u_asserts (
  .clk   (clk),
  .rst   (rst),
  .cs    (cs),
  .busy  (busy),
  .issue (issue),
  .rdone (rdone),
  .wdone (wdone),
  .count (count)
);

`default_nettype wire

// File: tb_rcn_ring.sv
`timescale 1ns/1ps
`default_nettype none
`include "rcn_settings.svh"

module tb_rcn_ring;

  localparam int N        = `RCN_NUM_MASTERS;
  localparam int NROWS    = 23 + 4 * N;
  localparam int LAST_GRP = 12;
  localparam int BP_GRP   = 9;   // flood on station 0 while station 1 queues five requests.
  localparam int LIMIT    = NROWS * (`RCN_BUF_DEPTH + 1) * (`RCN_NUM_MASTERS + 2) * 4;

  typedef struct packed {
    logic [3:0]          stn;
    logic                wr;
    rcn_pkg::rcn_mask_t  mask;
    rcn_pkg::rcn_baddr_t baddr;
    rcn_pkg::rcn_data_t  wdata;
    logic [7:0]          grp;
    rcn_pkg::rcn_seq_t   seq;
  } row_t;

  logic              clk;
  logic              rst;
  logic [N-1:0]      cs;
  rcn_pkg::rcn_req_t req [N];
  logic [N-1:0]      busy;
  logic [N-1:0]      issue;
  rcn_pkg::rcn_seq_t iss_seq [N];
  logic [N-1:0]      rdone;
  logic [N-1:0]      wdone;
  rcn_pkg::rcn_rsp_t rsp [N];

  row_t               rows [NROWS];
  string              names [NROWS];
  bit                 row_bad [NROWS];
  int                 nrows_used;
  rcn_pkg::rcn_seq_t  seq_next [N];
  rcn_pkg::rcn_data_t ref_mem [`RCN_MEM_WORDS];  // reference copy of the slave memory.
  int                 cur_row [N];               // row presented on each station's port.
  int                 drv_q [N][$];
  int                 iss_q [N][$];              // accepted, waiting for issue.
  int                 rsp_q [N][$];              // issued, waiting for a response.
  int                 level [N];
  bit                 saw_busy [N];
  int                 left_in_group;
  int                 errors;
  int                 passes;
  int                 cycles;
  integer             seed;
  bit                 mon_on;

  rcn_ring_top u_dut (
    .clk     (clk),
    .rst     (rst),
    .cs      (cs),
    .req     (req),
    .busy    (busy),
    .issue   (issue),
    .iss_seq (iss_seq),
    .rdone   (rdone),
    .wdone   (wdone),
    .rsp     (rsp)
  );

  always #10 clk = ~clk;

  function automatic rcn_pkg::rcn_req_t make_req(input row_t row);
    rcn_pkg::rcn_req_t rq;
    rq.seq   = row.seq;
    rq.wr    = row.wr;
    rq.mask  = row.wr ? row.mask : 4'h0;
    rq.addr  = row.baddr[21:2];
    rq.wdata = row.wdata;
    return rq;
  endfunction

  // each enabled lane takes the new byte, the others keep the stored one.
  function automatic rcn_pkg::rcn_data_t merge_bytes(input rcn_pkg::rcn_data_t old_w,
                                                     input rcn_pkg::rcn_data_t new_w,
                                                     input rcn_pkg::rcn_mask_t mask);
    rcn_pkg::rcn_data_t res;
    res = old_w;
    for (int b = 0; b < 4; b++) begin
      if (mask[b]) res[8*b +: 8] = new_w[8*b +: 8];
    end
    return res;
  endfunction

  task automatic add_row(input string name, input int stn, input bit wr,
                         input logic [3:0] mask, input logic [21:0] baddr,
                         input logic [31:0] wdata, input int grp);
    row_t row;
    row.stn   = stn[3:0];
    row.wr    = wr;
    row.mask  = mask;
    row.baddr = baddr;
    row.wdata = wdata;
    row.grp   = grp[7:0];
    row.seq   = seq_next[stn];
    seq_next[stn] = seq_next[stn] + 2'd1;  // tags wrap after four requests.
    rows[nrows_used]    = row;
    names[nrows_used]   = name;
    row_bad[nrows_used] = 1'b0;
    nrows_used++;
  endtask

  task automatic build_table();
    add_row("wr_full", 0, 1, 4'hf, 22'h000040, 32'ha5a51234, 1);
    add_row("rd_full", 0, 0, 4'h0, 22'h000040, 32'h0, 2);
    add_row("wr_base", 1, 1, 4'hf, 22'h000080, 32'h11223344, 3);
    add_row("wr_byte0", 1, 1, 4'h1, 22'h000080, 32'hdeadbeab, 4);
    add_row("wr_byte2", 1, 1, 4'h4, 22'h000080, 32'hfacdface, 5);
    add_row("rd_merged", 1, 0, 4'h0, 22'h000080, 32'h0, 6);
    add_row("wr_cross", 0, 1, 4'hf, 22'h0000c0, 32'h5a5ac3c3, 7);
    add_row("rd_cross", N - 1, 0, 4'h0, 22'h0000c0, 32'h0, 8);
    for (int i = 0; i < 5; i++) begin
      add_row($sformatf("bp_flood%0d", i), 0, 1, 4'hf, 22'(22'h000100 + 4 * i),
              $random(seed), BP_GRP);
    end
    for (int i = 0; i < 5; i++) begin
      add_row($sformatf("bp_queue%0d", i), 1, 1, 4'hf, 22'(22'h000200 + 4 * i),
              $random(seed), BP_GRP);
    end
    for (int i = 0; i < 5; i++) begin
      add_row($sformatf("bp_read%0d", i), 1, 0, 4'h0, 22'(22'h000200 + 4 * i), 32'h0, 10);
    end
    for (int k = 0; k < N; k++) begin
      for (int i = 0; i < 2; i++) begin
        add_row($sformatf("all_wr_s%0d_%0d", k, i), k, 1, 4'hf,
                22'(22'h000300 + 16 * k + 4 * i), $random(seed), 11);
      end
    end
    for (int k = 0; k < N; k++) begin
      for (int i = 0; i < 2; i++) begin
        add_row($sformatf("all_rd_s%0d_%0d", k, i), k, 0, 4'h0,
                22'(22'h000300 + 16 * k + 4 * i), 32'h0, 12);
      end
    end
  endtask

  task automatic report_fail(input int r, input string what,
                             input logic [31:0] exp, input logic [31:0] act);
    errors++;
    row_bad[r] = 1'b1;
    $display("[FAIL] %s: %s expected %h, actual %h", names[r], what, exp, act);
  endtask

  task automatic finish_row(input int k);
    int                     r;
    logic [`RCN_MEM_AW-1:0] idx;
    rcn_pkg::rcn_data_t     exp_data;
    rcn_pkg::rcn_baddr_t    exp_addr;
    rcn_pkg::rcn_mask_t     exp_mask;
    if (rsp_q[k].size() == 0) begin
      errors++;
      $display("station %0d received a response that it never issued", k);
    end else begin
      r = rsp_q[k].pop_front();
      idx = rows[r].baddr[`RCN_MEM_AW+1:2];  // the memory aliases on the low word bits.
      if (rows[r].wr) ref_mem[idx] = merge_bytes(ref_mem[idx], rows[r].wdata, rows[r].mask);
      exp_data = ref_mem[idx];
      exp_addr = {rows[r].baddr[21:2], 2'b00};
      exp_mask = rows[r].wr ? rows[r].mask : 4'h0;
      left_in_group--;
      if (wdone[k] !== rows[r].wr) begin
        report_fail(r, "wdone", 32'(rows[r].wr), 32'(wdone[k]));
      end else if (rdone[k] !== !rows[r].wr) begin
        report_fail(r, "rdone", 32'(!rows[r].wr), 32'(rdone[k]));
      end else if (rsp[k].seq !== rows[r].seq) begin
        report_fail(r, "rsp_seq", 32'(rows[r].seq), 32'(rsp[k].seq));
      end else if (rsp[k].addr !== exp_addr) begin
        report_fail(r, "rsp_addr", 32'(exp_addr), 32'(rsp[k].addr));
      end else if (rsp[k].mask !== exp_mask) begin
        report_fail(r, "rsp_mask", 32'(exp_mask), 32'(rsp[k].mask));
      end else if (rsp[k].data !== exp_data) begin
        report_fail(r, "rsp_data", exp_data, rsp[k].data);
      end else if (!row_bad[r]) begin
        passes++;
        $display("[PASS] %s", names[r]);
      end
    end
  endtask

  task automatic check_station(input int k);
    int r;
    if (busy[k] !== (level[k] == `RCN_BUF_DEPTH)) begin
      errors++;
      $display("station %0d shows busy %b while holding %0d requests", k, busy[k], level[k]);
    end
    if (busy[k]) saw_busy[k] = 1'b1;
    if (issue[k]) begin
      if (iss_q[k].size() == 0) begin
        errors++;
        $display("station %0d issued although no request was waiting", k);
      end else begin
        r = iss_q[k].pop_front();
        if (iss_seq[k] !== rows[r].seq) report_fail(r, "iss_seq", 32'(rows[r].seq),
                                                    32'(iss_seq[k]));
        rsp_q[k].push_back(r);
      end
      level[k]--;
    end
    if (cs[k] && !busy[k]) begin
      iss_q[k].push_back(cur_row[k]);  // taken at the coming rising edge.
      level[k]++;
    end
    if (rdone[k] || wdone[k]) finish_row(k);
  endtask

  always @(negedge clk) begin
    if (mon_on) begin
      for (int k = 0; k < N; k++) begin
        check_station(k);
      end
    end
  end

  task automatic check_idle(input int ncycles);
    logic [N-1:0] seen;
    seen = '0;
    repeat (ncycles) begin
      @(negedge clk);
      seen = seen | busy | issue | rdone | wdone;
    end
    if (seen === '0) begin
      passes++;
      $display("[PASS] reset_idle");
    end else begin
      errors++;
      $display("[FAIL] reset_idle: strobes expected %b, actual %b", {N{1'b0}}, seen);
    end
  endtask

  task automatic run_group(input int g);
    bit driving;
    left_in_group = 0;
    for (int r = 0; r < nrows_used; r++) begin
      if (rows[r].grp == g) begin
        drv_q[rows[r].stn].push_back(r);
        left_in_group++;
      end
    end
    driving = 1'b1;
    while (driving) begin
      @(posedge clk);
      driving = 1'b0;
      for (int k = 0; k < N; k++) begin
        if (drv_q[k].size() != 0) begin
          cs[k]      <= 1'b1;
          req[k]     <= make_req(rows[drv_q[k][0]]);
          cur_row[k] = drv_q[k][0];
          driving    = 1'b1;
        end else begin
          cs[k] <= 1'b0;
        end
      end
      @(negedge clk);
      for (int k = 0; k < N; k++) begin
        if (cs[k] && !busy[k]) void'(drv_q[k].pop_front());  // accepted at the next edge.
      end
    end
    while (left_in_group != 0) @(posedge clk);
  endtask

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= LIMIT) begin
      $display("timeout after %0d cycles, %0d responses still missing", cycles, left_in_group);
      $display("Result: FAILED");
      $finish;
    end
  end

  initial begin
    clk    = 1'b0;
    rst    = 1'b1;
    cs     = '0;
    seed   = 32'h84cdbaf7;
    errors = 0;
    passes = 0;
    cycles = 0;
    mon_on = 1'b0;
    nrows_used = 0;
    for (int k = 0; k < N; k++) begin
      req[k]      = '0;
      cur_row[k]  = 0;
      level[k]    = 0;
      seq_next[k] = '0;
      saw_busy[k] = 1'b0;
    end
    build_table();
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    check_idle(4);
    @(posedge clk);
    mon_on = 1'b1;
    for (int g = 1; g <= LAST_GRP; g++) begin
      if (g == BP_GRP) saw_busy[1] = 1'b0;
      run_group(g);
      if (g == BP_GRP) begin
        if (saw_busy[1]) begin
          passes++;
          $display("[PASS] bp_busy");
        end else begin
          errors++;
          $display("[FAIL] bp_busy: busy on station 1 expected 1, actual 0");
        end
      end
    end
    repeat (2) @(posedge clk);
    $display("%0d tests passed, %0d errors", passes, errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: tb.f
+incdir+.
rcn_pkg.sv
rcn_master.sv
rcn_master_buf.sv
rcn_slave_mem.sv
rcn_ring_top.sv
rcn_ring_asserts.sv
tb_rcn_ring.sv

// File: run.sh
#!/bin/sh
# Build the rcn ring testbench with Verilator, run it and check the log.
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f tb.f \
  --top-module tb_rcn_ring -o tb_rcn_ring || exit 1
./obj_dir/tb_rcn_ring > sim.log 2>&1 || echo "simulation stopped with an error" >> sim.log
cat sim.log
grep -q "Result: FAILED" sim.log && echo "simulation failed" && exit 1
grep -q "Result: PASSED" sim.log || { echo "no result line in the log"; exit 1; }
exit 0
